/* design/pcs_10g_loopback.sv */
// Top level of the 10GBASE-R PCS loopback used for the FPGA link test.
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module pcs_10g_loopback (
	input  logic                    tx_par_clk,
	input  logic                    nreset,
	input  logic                    rx_locked_i,
	input  logic [`PCS_BLOCK_W-1:0] rx_par_data_i,
	output logic [`PCS_BLOCK_W-1:0] tx_par_data_o
);
	import pcs_pkg::*;

	logic                    good_done;
	logic                    bad_limit;
	logic                    counter_clear;
	logic                    block_lock;
	logic                    rx_ctrl;
	logic                    rx_idle;
	logic [`PCS_START_N-1:0] rx_start;
	logic                    rx_term;
	logic                    rx_err;
	logic [`PCS_DATA_W-1:0]  rx_data;
	logic [`PCS_KEEP_W-1:0]  rx_keep;

	pcs_sh_counter m_sh_counter (
		.tx_par_clk  (tx_par_clk),
		.nreset      (nreset),
		.clear_i     (counter_clear),
		.sync_hdr_i  (sync_hdr_e'(rx_par_data_i[1:0])), // Raw header, may be invalid.
		.good_done_o (good_done),
		.bad_limit_o (bad_limit)
	);

	pcs_lock_fsm m_lock_fsm (
		.tx_par_clk      (tx_par_clk),
		.nreset          (nreset),
		.rx_locked_i     (rx_locked_i),
		.good_done_i     (good_done),
		.bad_limit_i     (bad_limit),
		.counter_clear_o (counter_clear),
		.block_lock_o    (block_lock)
	);

	pcs_rx_decode m_rx_decode (
		.tx_par_clk    (tx_par_clk),
		.nreset        (nreset),
		.block_lock_i  (block_lock),
		.rx_par_data_i (rx_par_data_i),
		.ctrl_o        (rx_ctrl),
		.idle_o        (rx_idle),
		.start_o       (rx_start),
		.term_o        (rx_term),
		.err_o         (rx_err),
		.data_o        (rx_data),
		.keep_o        (rx_keep)
	);

	pcs_tx_encode m_tx_encode (
		.tx_par_clk    (tx_par_clk),
		.nreset        (nreset),
		.ctrl_i        (rx_ctrl),
		.idle_i        (rx_idle),
		.start_i       (rx_start),
		.term_i        (rx_term),
		.err_i         (rx_err),
		.data_i        (rx_data),
		.keep_i        (rx_keep),
		.tx_par_data_o (tx_par_data_o)
	);

endmodule

/* design/pcs_cfg.svh */
// Widths, lock thresholds and reset delay shared by the PCS loopback RTL and its testbench.
`ifndef PCS_CFG_SVH
`define PCS_CFG_SVH

// Block geometry.
`define PCS_DATA_W 64  // Payload bits per block.
`define PCS_BLOCK_W 66 // Sync header plus payload.
`define PCS_KEEP_W 8   // One keep bit per payload byte.
`define PCS_START_N 2  // Start lanes 0 and 4.

// Block lock.
`define PCS_LOCK_GOOD 16 // Consecutive valid headers to gain lock.
`define PCS_BAD_MAX 4    // Invalid headers in a window that drop lock.
`define PCS_WINDOW 32    // Window length in blocks.

// Transmit side.
`define PCS_TX_RST_DLY 4 // Cycles the transmitter stays in reset after nreset.

`endif

/* design/pcs_lock_fsm.sv */
// Block lock FSM driven by the sync header counter and the serdes CDR lock.
`timescale 1ns/1ps

module pcs_lock_fsm (
	input  logic tx_par_clk,
	input  logic nreset,
	input  logic rx_locked_i,
	input  logic good_done_i,
	input  logic bad_limit_i,
	output logic counter_clear_o,
	output logic block_lock_o
);
	import pcs_pkg::*;

	lock_state_e state;
	lock_state_e state_next;

	always_comb begin
		state_next = state;
		case (state)
			LS_RESET: begin
				if (rx_locked_i)
					state_next = LS_HUNT;
			end
			LS_HUNT: begin
				if (good_done_i)
					state_next = LS_LOCKED; // Enough valid headers in a row.
			end
			LS_LOCKED: begin
				if (bad_limit_i)
					state_next = LS_HUNT; // Too many bad headers in this window.
			end
			default: begin
				state_next = LS_RESET;
			end
		endcase

		// Losing the CDR overrides everything.
		if (!rx_locked_i)
			state_next = LS_RESET;
	end

	always_ff @(posedge tx_par_clk) begin
		if (!nreset)
			state <= LS_RESET;
		else
			state <= state_next;
	end

	// Counters stay clear in RESET, so a relock needs a full run of good headers.
	// Clearing again on the HUNT to LOCKED edge starts the first window at lock.
	// In HUNT the counter runs freely to find the run.
	assign counter_clear_o = (state == LS_RESET) || ((state == LS_HUNT) && good_done_i);

	assign block_lock_o = (state == LS_LOCKED);

endmodule

/* design/pcs_pkg.sv */
// Block codes, lock states and the byte mask helper shared by the PCS loopback modules.
`include "pcs_cfg.svh"

package pcs_pkg;

	typedef enum logic [1:0] {
		SH_DATA = 2'b01,
		SH_CTRL = 2'b10
	} sync_hdr_e;

	// Type byte of a control block, bits 9:2.
	typedef enum logic [7:0] {
		BT_IDLE   = 8'h1E,
		BT_START0 = 8'h78,
		BT_START4 = 8'h33,
		BT_TERM0  = 8'h87,
		BT_TERM1  = 8'h99,
		BT_TERM2  = 8'hAA,
		BT_TERM3  = 8'hB4,
		BT_TERM4  = 8'hCC,
		BT_TERM5  = 8'hD2,
		BT_TERM6  = 8'hE1,
		BT_TERM7  = 8'hFF
	} blk_type_e;

	typedef enum logic [1:0] {LS_RESET, LS_HUNT, LS_LOCKED} lock_state_e;

	typedef enum logic [6:0] {
		CC_IDLE  = 7'h00,
		CC_ERROR = 7'h1E
	} ctrl_code_e;

	// Expands a byte keep into a bit mask.
	function automatic logic [`PCS_DATA_W-1:0] byte_mask(input logic [`PCS_KEEP_W-1:0] keep);
		logic [`PCS_DATA_W-1:0] mask;
		for (int i = 0; i < `PCS_KEEP_W; i++)
			mask[i*8 +: 8] = {8{keep[i]}};
		return mask;
	endfunction

endpackage

/* design/pcs_rx_decode.sv */
// Receive decoder that registers each 66-bit block as control flags, data and byte keep.
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module pcs_rx_decode (
	input  logic                    tx_par_clk,
	input  logic                    nreset,
	input  logic                    block_lock_i,
	input  logic [`PCS_BLOCK_W-1:0] rx_par_data_i,
	output logic                    ctrl_o,
	output logic                    idle_o,
	output logic [`PCS_START_N-1:0] start_o,
	output logic                    term_o,
	output logic                    err_o,
	output logic [`PCS_DATA_W-1:0]  data_o,
	output logic [`PCS_KEEP_W-1:0]  keep_o
);
	import pcs_pkg::*;

	localparam int PAYLOAD_W = `PCS_DATA_W - 8; // Control payload after the type byte.

	sync_hdr_e               hdr;
	blk_type_e               blk_type;
	logic [PAYLOAD_W-1:0]    ctrl_payload;
	logic                    ctrl_d;
	logic                    idle_d;
	logic [`PCS_START_N-1:0] start_d;
	logic                    term_d;
	logic                    err_d;
	logic [`PCS_DATA_W-1:0]  data_d;
	logic [`PCS_KEEP_W-1:0]  keep_d;

	// Valid data bytes of a terminate block, from the low lane up.
	function automatic logic [`PCS_KEEP_W-1:0] term_keep(input blk_type_e t);
		case (t)
			BT_TERM1: return 8'h01;
			BT_TERM2: return 8'h03;
			BT_TERM3: return 8'h07;
			BT_TERM4: return 8'h0F;
			BT_TERM5: return 8'h1F;
			BT_TERM6: return 8'h3F;
			BT_TERM7: return 8'h7F;
			default:  return 8'h00;
		endcase
	endfunction

	assign hdr          = sync_hdr_e'(rx_par_data_i[1:0]);
	assign blk_type     = blk_type_e'(rx_par_data_i[9:2]);
	assign ctrl_payload = rx_par_data_i[`PCS_BLOCK_W-1:10];

	always_comb begin
		ctrl_d  = 1'b1;
		idle_d  = 1'b0;
		start_d = '0;
		term_d  = 1'b0;
		err_d   = 1'b0;
		data_d  = '0;
		keep_d  = '0;

		if (!block_lock_i) begin
			idle_d = 1'b1; // Report idle until lock.
		end else if (hdr == SH_DATA) begin
			ctrl_d = 1'b0;
			data_d = rx_par_data_i[`PCS_BLOCK_W-1:2];
			keep_d = '1;
		end else if (hdr == SH_CTRL) begin
			case (blk_type)
				BT_IDLE: begin
					idle_d = 1'b1;
				end
				BT_START0: begin
					start_d[0] = 1'b1;
					data_d     = {ctrl_payload, 8'h00}; // Lane 0 holds the start character.
					keep_d     = 8'hFE;
				end
				BT_START4: begin
					start_d[1] = 1'b1;
					data_d     = {ctrl_payload[55:32], 40'h0}; // Lanes 5 to 7.
					keep_d     = 8'hE0;
				end
				BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
				BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7: begin
					term_d = 1'b1;
					keep_d = term_keep(blk_type);
					data_d = {8'h00, ctrl_payload} & byte_mask(keep_d);
				end
				default: begin
					err_d = 1'b1; // Unknown type byte.
				end
			endcase
		end else begin
			err_d = 1'b1; // Header 00 or 11.
		end
	end

	always_ff @(posedge tx_par_clk) begin
		if (!nreset) begin
			ctrl_o  <= 1'b0;
			idle_o  <= 1'b0;
			start_o <= '0;
			term_o  <= 1'b0;
			err_o   <= 1'b0;
		end else begin
			ctrl_o  <= ctrl_d;
			idle_o  <= idle_d;
			start_o <= start_d;
			term_o  <= term_d;
			err_o   <= err_d;
		end
	end

	always_ff @(posedge tx_par_clk) begin
		data_o <= data_d;
		keep_o <= keep_d;
	end

endmodule

/* design/pcs_sh_counter.sv */
// Sync header counters that feed good and bad header events to the block lock FSM.
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module pcs_sh_counter (
	input  logic               tx_par_clk,
	input  logic               nreset,
	input  logic               clear_i,
	input  pcs_pkg::sync_hdr_e sync_hdr_i,
	output logic               good_done_o,
	output logic               bad_limit_o
);
	import pcs_pkg::*;

	localparam int GOOD_W = $clog2(`PCS_LOCK_GOOD + 1);
	localparam int BAD_W  = $clog2(`PCS_BAD_MAX + 1);
	localparam int WIN_W  = $clog2(`PCS_WINDOW);

	logic              hdr_valid;
	logic              win_last;
	logic [GOOD_W-1:0] good_cnt;
	logic [BAD_W-1:0]  bad_cnt;
	logic [WIN_W-1:0]  win_cnt;

	assign hdr_valid = (sync_hdr_i == SH_DATA) || (sync_hdr_i == SH_CTRL);
	assign win_last  = (win_cnt == WIN_W'(`PCS_WINDOW - 1)); // Last block of the window.

	// Consecutive valid headers, saturating at the lock threshold.
	always_ff @(posedge tx_par_clk) begin
		if (!nreset || clear_i) begin
			good_cnt <= '0;
		end else if (!hdr_valid) begin
			good_cnt <= '0; // Any bad header restarts the run.
		end else if (good_cnt != GOOD_W'(`PCS_LOCK_GOOD)) begin
			good_cnt <= good_cnt + 1'b1;
		end
	end

	assign good_done_o = (good_cnt == GOOD_W'(`PCS_LOCK_GOOD));

	// Invalid headers per window.
	always_ff @(posedge tx_par_clk) begin
		if (!nreset || clear_i) begin
			win_cnt     <= '0;
			bad_cnt     <= '0;
			bad_limit_o <= 1'b0;
		end else begin
			win_cnt     <= win_last ? '0 : win_cnt + 1'b1;
			bad_limit_o <= !hdr_valid && (bad_cnt == BAD_W'(`PCS_BAD_MAX - 1));
			if (win_last)
				bad_cnt <= '0;
			else if (!hdr_valid && (bad_cnt != BAD_W'(`PCS_BAD_MAX)))
				bad_cnt <= bad_cnt + 1'b1;
		end
	end

endmodule

/* design/pcs_tx_encode.sv */
// Transmit side with reset delay, loopback register and 66-bit block encoder.
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module pcs_tx_encode (
	input  logic                    tx_par_clk,
	input  logic                    nreset,
	input  logic                    ctrl_i,
	input  logic                    idle_i,
	input  logic [`PCS_START_N-1:0] start_i,
	input  logic                    term_i,
	input  logic                    err_i,
	input  logic [`PCS_DATA_W-1:0]  data_i,
	input  logic [`PCS_KEEP_W-1:0]  keep_i,
	output logic [`PCS_BLOCK_W-1:0] tx_par_data_o
);
	import pcs_pkg::*;

	localparam logic [55:0] IDLE_CODES = {8{CC_IDLE}};
	localparam logic [55:0] ERR_CODES  = {8{CC_ERROR}};
	localparam logic [`PCS_BLOCK_W-1:0] IDLE_BLOCK = {IDLE_CODES, BT_IDLE, SH_CTRL};
	localparam logic [`PCS_BLOCK_W-1:0] ERR_BLOCK  = {ERR_CODES, BT_IDLE, SH_CTRL};

	logic [`PCS_TX_RST_DLY-1:0] rst_chain;
	logic                       tx_rst_n;
	logic                       lb_ctrl;
	logic                       lb_idle;
	logic [`PCS_START_N-1:0]    lb_start;
	logic                       lb_term;
	logic                       lb_err;
	logic [`PCS_DATA_W-1:0]     lb_data;
	logic [`PCS_KEEP_W-1:0]     lb_keep;
	logic [`PCS_DATA_W-1:0]     lb_masked;
	logic [`PCS_BLOCK_W-1:0]    block_d;

	// Terminate type from the number of valid low bytes.
	function automatic blk_type_e term_type(input logic [`PCS_KEEP_W-1:0] keep);
		case (keep)
			8'h01:   return BT_TERM1;
			8'h03:   return BT_TERM2;
			8'h07:   return BT_TERM3;
			8'h0F:   return BT_TERM4;
			8'h1F:   return BT_TERM5;
			8'h3F:   return BT_TERM6;
			8'h7F:   return BT_TERM7;
			default: return BT_TERM0;
		endcase
	endfunction

	// Transmit reset release, one stage per cycle.
	always_ff @(posedge tx_par_clk) begin
		if (!nreset)
			rst_chain <= '0;
		else
			rst_chain <= {rst_chain[`PCS_TX_RST_DLY-2:0], 1'b1};
	end

	assign tx_rst_n = rst_chain[`PCS_TX_RST_DLY-1];

	// Loopback stage between receive and transmit.
	always_ff @(posedge tx_par_clk) begin
		lb_ctrl  <= ctrl_i;
		lb_idle  <= idle_i;
		lb_start <= start_i;
		lb_term  <= term_i;
		lb_err   <= err_i;
		lb_data  <= data_i;
		lb_keep  <= keep_i;
	end

	assign lb_masked = lb_data & byte_mask(lb_keep);

	// Idle control codes are zero, so pad bits and unused lanes come from the mask.
	always_comb begin
		if (!lb_ctrl)
			block_d = {lb_masked, SH_DATA};
		else if (lb_err)
			block_d = ERR_BLOCK;
		else if (lb_start[0])
			block_d = {lb_masked[63:8], BT_START0, SH_CTRL};
		else if (lb_start[1])
			block_d = {lb_masked[63:40], 4'h0, {4{CC_IDLE}}, BT_START4, SH_CTRL};
		else if (lb_term)
			block_d = {lb_masked[55:0], term_type(lb_keep), SH_CTRL};
		else if (lb_idle)
			block_d = IDLE_BLOCK;
		else
			block_d = ERR_BLOCK; // Control block with no known kind.
	end

	always_ff @(posedge tx_par_clk) begin
		if (!nreset || !tx_rst_n)
			tx_par_data_o <= IDLE_BLOCK;
		else
			tx_par_data_o <= block_d;
	end

endmodule

/* dv/pcs_loopback_assertions.sv */
// Concurrent checks on lock and transmit blocks, bound into the PCS loopback top level.
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module pcs_loopback_assertions (
	input logic                    tx_par_clk,
	input logic                    nreset,
	input logic                    rx_locked_i,
	input logic                    block_lock_i,
	input logic [`PCS_BLOCK_W-1:0] tx_par_data_i
);
	localparam int CNT_W = $clog2(`PCS_TX_RST_DLY + 1);
	localparam logic [`PCS_BLOCK_W-1:0] IDLE_BLOCK = {56'h0, 8'h1E, 2'b10};

	logic [CNT_W-1:0] rst_cycles; // Cycles since nreset released, saturating.

	always_ff @(posedge tx_par_clk) begin
		if (!nreset)
			rst_cycles <= '0;
		else if (rst_cycles != CNT_W'(`PCS_TX_RST_DLY))
			rst_cycles <= rst_cycles + 1'b1;
	end

	assert property (@(posedge tx_par_clk) disable iff (!nreset)
		!rx_locked_i |=> !block_lock_i)
		else $error("Block lock held after the serdes lock dropped");

	assert property (@(posedge tx_par_clk) disable iff (!nreset)
		(tx_par_data_i[1:0] == 2'b01) || (tx_par_data_i[1:0] == 2'b10))
		else $error("Transmit block has an invalid sync header");

	assert property (@(posedge tx_par_clk)
		nreset && (rst_cycles < CNT_W'(`PCS_TX_RST_DLY)) |-> (tx_par_data_i == IDLE_BLOCK))
		else $error("Transmit block not idle during the reset delay");

endmodule

bind pcs_10g_loopback pcs_loopback_assertions m_assertions (
	.tx_par_clk    (tx_par_clk),
	.nreset        (nreset),
	.rx_locked_i   (rx_locked_i),
	.block_lock_i  (block_lock),
	.tx_par_data_i (tx_par_data_o)
);

/* dv/tb_pcs_loopback.sv */
// Testbench for the PCS loopback top level; applies a table of 66-bit blocks and checks the echo.
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module tb_pcs_loopback;

	localparam int CLK_PERIOD = 20;
	localparam int LATENCY    = 3; // Decode, loopback and output registers.
	localparam logic [`PCS_BLOCK_W-1:0] IDLE_BLOCK = {56'h0, 8'h1E, 2'b10};
	localparam logic [`PCS_BLOCK_W-1:0] ERR_BLOCK  = {{8{7'h1E}}, 8'h1E, 2'b10};
	// Terminate types indexed by the number of data bytes.
	localparam logic [7:0] TERM_TYPES [8] = '{8'h87, 8'h99, 8'hAA, 8'hB4,
		8'hCC, 8'hD2, 8'hE1, 8'hFF};

	logic                    tx_par_clk;
	logic                    nreset;
	logic                    rx_locked_i;
	logic [`PCS_BLOCK_W-1:0] rx_par_data_i;
	logic [`PCS_BLOCK_W-1:0] tx_par_data_o;

	logic [31:0]             lfsr_state = 32'hddef_549a;
	bit                      table_ready = 1'b0;
	string                   tbl_name[$];
	logic [`PCS_BLOCK_W-1:0] tbl_blk[$];
	bit                      tbl_locked[$];
	logic [`PCS_BLOCK_W-1:0] tbl_exp[$];
	string                   pend_name[$]; // Expected blocks in flight through the DUT.
	logic [`PCS_BLOCK_W-1:0] pend_exp[$];

	pcs_10g_loopback dut (
		.tx_par_clk    (tx_par_clk),
		.nreset        (nreset),
		.rx_locked_i   (rx_locked_i),
		.rx_par_data_i (rx_par_data_i),
		.tx_par_data_o (tx_par_data_o)
	);

	// Fibonacci LFSR with taps 32 22 2 1.
	function automatic logic next_lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] random_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v[k] = next_lfsr_bit();
		return v;
	endfunction

	function automatic logic [`PCS_BLOCK_W-1:0] data_block();
		return {random_bits(64), 2'b01};
	endfunction

	function automatic logic [`PCS_BLOCK_W-1:0] ctrl_block(input logic [7:0] blk_type);
		logic [63:0] bits;
		bits = random_bits(56);
		return {bits[55:0], blk_type, 2'b10};
	endfunction

	function automatic logic [`PCS_BLOCK_W-1:0] bad_header_block(input bit ones);
		return {random_bits(64), ones ? 2'b11 : 2'b00};
	endfunction

	// Expected echo of one block while the link is locked.
	function automatic logic [`PCS_BLOCK_W-1:0] loopback_model(
			input logic [`PCS_BLOCK_W-1:0] blk);
		logic [`PCS_BLOCK_W-1:0] res;
		int kept;
		res = blk;
		kept = -1;
		if (blk[1:0] == 2'b01)
			return blk; // Data passes unchanged.
		if (blk[1:0] != 2'b10)
			return ERR_BLOCK;
		if (blk[9:2] == 8'h1E)
			return IDLE_BLOCK;
		if (blk[9:2] == 8'h78)
			return blk;
		if (blk[9:2] == 8'h33) begin
			res[41:10] = '0; // Only lanes 5 to 7 carry data.
			return res;
		end
		for (int k = 0; k < 8; k++)
			if (blk[9:2] == TERM_TYPES[k])
				kept = k;
		if (kept < 0)
			return ERR_BLOCK;
		for (int k = kept; k < 7; k++)
			res[10 + 8*k +: 8] = 8'h00; // Bytes past the end of frame.
		return res;
	endfunction

	task automatic add_entry(input string name, input logic [`PCS_BLOCK_W-1:0] blk,
			input bit locked, input bit expect_idle);
		tbl_name.push_back($sformatf("%s[%0d]", name, tbl_blk.size()));
		tbl_blk.push_back(blk);
		tbl_locked.push_back(locked);
		tbl_exp.push_back(expect_idle ? IDLE_BLOCK : loopback_model(blk));
	endtask

	task automatic build_table();
		// First locked block only starts the hunt; 16 good headers and one more block stay idle.
		add_entry("acquire", IDLE_BLOCK, 1'b1, 1'b1);
		for (int i = 0; i < 17; i++)
			add_entry("acquire", data_block(), 1'b1, 1'b1);
		for (int i = 0; i < 8; i++)
			add_entry("data", data_block(), 1'b1, 1'b0);
		add_entry("start_lane0", ctrl_block(8'h78), 1'b1, 1'b0);
		add_entry("start_lane4", ctrl_block(8'h33), 1'b1, 1'b0);
		for (int n = 0; n < 8; n++)
			add_entry($sformatf("term_%0d", n), ctrl_block(TERM_TYPES[n]), 1'b1, 1'b0);
		add_entry("bad_type", ctrl_block(8'h55), 1'b1, 1'b0);
		// Four bad headers in the first window. The block after the fourth still loops.
		for (int i = 0; i < 4; i++) begin
			add_entry("hdr_err", bad_header_block((i % 2) == 1), 1'b1, 1'b0);
			add_entry("hdr_err", data_block(), 1'b1, 1'b0);
		end
		for (int i = 0; i < 16; i++)
			add_entry("lock_lost", data_block(), 1'b1, 1'b1);
		for (int i = 0; i < 4; i++)
			add_entry("relock", data_block(), 1'b1, 1'b0);
		add_entry("unlock", data_block(), 1'b0, 1'b0); // Decoded under the old lock.
		for (int i = 0; i < 2; i++)
			add_entry("unlock", data_block(), 1'b0, 1'b1);
		for (int i = 0; i < 18; i++)
			add_entry("reacquire", data_block(), 1'b1, 1'b1);
		for (int i = 0; i < 4; i++)
			add_entry("reacquire", data_block(), 1'b1, 1'b0);
	endtask

	task automatic check_output(input string name, input logic [`PCS_BLOCK_W-1:0] expected);
		assert (tx_par_data_o === expected) else begin
			$display("FAILED %s expected %h actual %h", name, expected, tx_par_data_o);
			$display("Regression failed");
			$fatal(1, "Output block mismatch");
		end
	endtask

	initial begin
		tx_par_clk = 1'b0;
		forever #(CLK_PERIOD / 2) tx_par_clk = ~tx_par_clk;
	end

	initial begin
		wait (table_ready);
		#((tbl_blk.size() + 40) * CLK_PERIOD);
		$display("Timeout: the stimulus table did not finish in the expected time");
		$display("Regression failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		nreset        = 1'b0;
		rx_locked_i   = 1'b0;
		rx_par_data_i = IDLE_BLOCK;
		build_table();
		table_ready = 1'b1;
		repeat (5) @(posedge tx_par_clk);
		nreset <= 1'b1;

		// Three extra cycles flush the last entries out of the pipeline.
		for (int i = 0; i < tbl_blk.size() + LATENCY; i++) begin
			@(posedge tx_par_clk);
			if (i < tbl_blk.size()) begin
				rx_par_data_i <= tbl_blk[i];
				rx_locked_i   <= tbl_locked[i];
				pend_name.push_back(tbl_name[i]);
				pend_exp.push_back(tbl_exp[i]);
			end else begin
				rx_par_data_i <= IDLE_BLOCK;
			end
			@(negedge tx_par_clk);
			if (i >= LATENCY)
				check_output(pend_name.pop_front(), pend_exp.pop_front());
		end

		$display("Regression passed");
		$finish;
	end

endmodule

/* files.f */
+incdir+design
design/pcs_pkg.sv
design/pcs_sh_counter.sv
design/pcs_lock_fsm.sv
design/pcs_rx_decode.sv
design/pcs_tx_encode.sv
design/pcs_10g_loopback.sv
dv/pcs_loopback_assertions.sv
dv/tb_pcs_loopback.sv

/* run.sh */
#!/bin/sh
# Compiles and runs the PCS loopback testbench with Verilator, then checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module tb_pcs_loopback -f files.f

./obj_dir/Vtb_pcs_loopback 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then
	echo "Simulation did not pass, see sim.log"
	exit 1
fi
echo "Simulation finished without errors"
